// File: hit_miss_unit.f
source/llc_geom_pkg.sv
source/llc_desc_pkg.sv
source/tag_store.sv
source/lock_table.sv
source/miss_counters.sv
source/hit_miss_ctrl.sv
source/hit_miss_unit.sv
sim/tb_hit_miss_assertions.sv
sim/tb_checker.sv
sim/tb_hit_miss_unit.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the hit/miss testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_hit_miss_unit -f hit_miss_unit.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -F -q "** FAIL **" sim.log; then
  exit 1
fi
exit 0

// File: sim/tb_checker.sv
// compares every output transfer of the DUT with the expected descriptor of the current row
// evict_tag is only compared where an eviction is expected
`timescale 1ns/1ps

module tb_checker (
  input  logic                clk_i,
  input  logic                rst_i,
  input  llc_desc_pkg::desc_t desc_i,
  input  logic                hit_valid_i,
  input  logic                hit_ready_i,
  input  logic                miss_valid_i,
  input  logic                miss_ready_i,
  input  llc_desc_pkg::desc_t exp_desc_i,
  input  logic                exp_miss_i,
  input  int                  row_i,
  input  logic                blocked_i,
  output int                  pass_cnt_o,
  output int                  fail_cnt_o
);

  // an output was seen while the row should still be held back
  logic blk_err_q;

  // prints one error line, returns 1 on a mismatch
  function automatic int check_field(input int row, input string name,
                                     input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR row %0d %s: got 0x%0h expected 0x%0h", row, name, got, exp);
      return 1;
    end
    return 0;
  endfunction

  always @(posedge clk_i) begin : compare
    int errs;
    errs = 0;
    if (rst_i) begin
      pass_cnt_o <= 0;
      fail_cnt_o <= 0;
      blk_err_q  <= 1'b0;
    end else begin
      if (blocked_i && (hit_valid_i || miss_valid_i) && !blk_err_q) begin
        $display("row %0d: output appeared while its line was still locked", row_i);
        blk_err_q <= 1'b1;
      end
      if ((hit_valid_i && hit_ready_i) || (miss_valid_i && miss_ready_i)) begin
        errs += check_field(row_i, "miss_valid_o", 32'(miss_valid_i), 32'(exp_miss_i));
        errs += check_field(row_i, "desc_o.addr", desc_i.addr.raw, exp_desc_i.addr.raw);
        errs += check_field(row_i, "desc_o.id", 32'(desc_i.id), 32'(exp_desc_i.id));
        errs += check_field(row_i, "desc_o.rw", 32'(desc_i.rw), 32'(exp_desc_i.rw));
        errs += check_field(row_i, "desc_o.flush", 32'(desc_i.flush), 32'(exp_desc_i.flush));
        errs += check_field(row_i, "desc_o.way_ind", 32'(desc_i.way_ind),
                            32'(exp_desc_i.way_ind));
        errs += check_field(row_i, "desc_o.refill", 32'(desc_i.refill),
                            32'(exp_desc_i.refill));
        errs += check_field(row_i, "desc_o.evict", 32'(desc_i.evict), 32'(exp_desc_i.evict));
        if (exp_desc_i.evict) begin
          errs += check_field(row_i, "desc_o.evict_tag", 32'(desc_i.evict_tag),
                              32'(exp_desc_i.evict_tag));
        end
        // a transfer while still blocked is a failure too
        if (errs == 0 && !blk_err_q && !blocked_i) begin
          $display("row %0d: ok", row_i);
          pass_cnt_o <= pass_cnt_o + 1;
        end else begin
          $display("row %0d: failed", row_i);
          fail_cnt_o <= fail_cnt_o + 1;
        end
        blk_err_q <= 1'b0;
      end
    end
  end

endmodule

// File: sim/tb_hit_miss_assertions.sv
// protocol checks bound into the hit/miss stage top
// the init window assumes one tag set is cleared per cycle after reset
`timescale 1ns/1ps

module tb_hit_miss_assertions (
  input logic                clk_i,
  input logic                rst_i,
  input logic                ready_o,
  input logic                hit_valid_o,
  input logic                miss_valid_o,
  input llc_desc_pkg::desc_t desc_o
);

  // cycles since reset was released, saturating
  logic [5:0] since_rst_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      since_rst_q <= '0;
    end else if (since_rst_q != '1) begin
      since_rst_q <= since_rst_q + 1'b1;
    end
  end

  // only one output path at a time
  one_path: assert property (@(posedge clk_i) disable iff (rst_i)
    !(hit_valid_o && miss_valid_o))
    else $error("hit and miss valid are high together");

  // a shown descriptor names at most one way
  way_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    (hit_valid_o || miss_valid_o) |-> $onehot0(desc_o.way_ind))
    else $error("desc_o.way_ind names more than one way");

  // no descriptor taken during the tag sweep
  init_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    (since_rst_q < 6'(llc_geom_pkg::num_sets)) |-> !ready_o)
    else $error("ready_o rose before the tag sweep could finish");

endmodule

// File: sim/tb_hit_miss_unit.sv
// directed table test of the hit/miss stage, one descriptor at a time
// expected ways assume a cleared cache, lowest free way first, then round robin per set
`timescale 1ns/1ps

module tb_hit_miss_unit;

  localparam int num_rows = 15;

  // one table row, op 0 read, 1 write, 2 flush
  typedef struct packed {
    logic [1:0]             op;
    llc_geom_pkg::tag_t     tag;
    llc_geom_pkg::index_t   index;
    llc_geom_pkg::id_t      id;
    // flush target, otherwise the expected way
    llc_geom_pkg::way_ind_t way;
    logic                   unlock;
    logic                   late;
    logic [1:0]             downs;
    logic                   miss;
    logic                   refill;
    logic                   evict;
    llc_geom_pkg::tag_t     etag;
  } row_t;

  logic clk_i;
  logic rst_i;
  llc_desc_pkg::desc_t desc_i;
  logic valid_i;
  logic ready_o;
  llc_desc_pkg::desc_t desc_o;
  logic hit_valid_o;
  logic hit_ready_i;
  logic miss_valid_o;
  logic miss_ready_i;
  llc_desc_pkg::lock_t w_unlock_i;
  logic w_unlock_req_i;
  logic w_unlock_gnt_o;
  llc_desc_pkg::lock_t r_unlock_i;
  logic r_unlock_req_i;
  logic r_unlock_gnt_o;
  llc_desc_pkg::cnt_t cnt_down_i;

  // expectation shared with the checker
  llc_desc_pkg::desc_t exp_desc;
  logic exp_miss;
  int row_idx;
  logic blocked;
  int pass_cnt;
  int fail_cnt;
  int misc_errs;
  row_t rows[$];
  logic [31:0] lfsr_q;

  hit_miss_unit #(
    .cnt_width ( 3 )
  ) u_dut (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .desc_i         ( desc_i         ),
    .valid_i        ( valid_i        ),
    .ready_o        ( ready_o        ),
    .desc_o         ( desc_o         ),
    .hit_valid_o    ( hit_valid_o    ),
    .hit_ready_i    ( hit_ready_i    ),
    .miss_valid_o   ( miss_valid_o   ),
    .miss_ready_i   ( miss_ready_i   ),
    .w_unlock_i     ( w_unlock_i     ),
    .w_unlock_req_i ( w_unlock_req_i ),
    .w_unlock_gnt_o ( w_unlock_gnt_o ),
    .r_unlock_i     ( r_unlock_i     ),
    .r_unlock_req_i ( r_unlock_req_i ),
    .r_unlock_gnt_o ( r_unlock_gnt_o ),
    .cnt_down_i     ( cnt_down_i     )
  );

  tb_checker u_checker (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .desc_i       ( desc_o       ),
    .hit_valid_i  ( hit_valid_o  ),
    .hit_ready_i  ( hit_ready_i  ),
    .miss_valid_i ( miss_valid_o ),
    .miss_ready_i ( miss_ready_i ),
    .exp_desc_i   ( exp_desc     ),
    .exp_miss_i   ( exp_miss     ),
    .row_i        ( row_idx      ),
    .blocked_i    ( blocked      ),
    .pass_cnt_o   ( pass_cnt     ),
    .fail_cnt_o   ( fail_cnt     )
  );

  bind hit_miss_unit tb_hit_miss_assertions u_assert (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .ready_o      ( ready_o      ),
    .hit_valid_o  ( hit_valid_o  ),
    .miss_valid_o ( miss_valid_o ),
    .desc_o       ( desc_o       )
  );

  //////////////////////////////////////////////////
  // clock, sinks and watchdog
  //////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // random back-pressure on both output paths
  initial begin
    lfsr_q       = 32'h9735;
    hit_ready_i  = 1'b0;
    miss_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      lfsr_q = lfsr_step(lfsr_q);
      hit_ready_i <= lfsr_q[0];
      lfsr_q = lfsr_step(lfsr_q);
      miss_ready_i <= lfsr_q[0];
    end
  end

  initial begin
    repeat (num_rows * 200 + llc_geom_pkg::num_sets + 8 + 20) @(posedge clk_i);
    $display("watchdog expired before all rows finished");
    $display("** FAIL **");
    $finish;
  end

  //////////////////////////////////////////////////
  // table and driver
  //////////////////////////////////////////////////

  task automatic add_row(input logic [1:0] op, input logic [23:0] tag, input logic [3:0] index,
                         input logic [3:0] id, input logic [3:0] way, input logic unlock,
                         input logic late, input logic [1:0] downs, input logic miss,
                         input logic refill, input logic evict, input logic [23:0] etag);
    rows.push_back({op, tag, index, id, way, unlock, late, downs, miss, refill, evict, etag});
  endtask

  // release the row's line, checks the same-cycle grant
  task automatic send_unlock(input int r, input logic use_write);
    llc_desc_pkg::lock_t l;
    l.index   = rows[r].index;
    l.way_ind = rows[r].way;
    if (use_write) begin
      w_unlock_i     <= l;
      w_unlock_req_i <= 1'b1;
    end else begin
      r_unlock_i     <= l;
      r_unlock_req_i <= 1'b1;
    end
    blocked <= 1'b0;
    @(posedge clk_i);
    if (use_write ? !w_unlock_gnt_o : !r_unlock_gnt_o) begin
      $display("row %0d: unlock grant did not pulse with its request", r);
      misc_errs++;
    end
    w_unlock_req_i <= 1'b0;
    r_unlock_req_i <= 1'b0;
  endtask

  task automatic run_row(input int r);
    llc_desc_pkg::desc_t d;
    d                    = '0;
    d.addr.fields.tag    = rows[r].tag;
    d.addr.fields.index  = rows[r].index;
    d.id                 = rows[r].id;
    d.rw                 = (rows[r].op == 2'd1);
    d.flush              = (rows[r].op == 2'd2);
    d.way_ind            = d.flush ? rows[r].way : '0;
    exp_desc             <= '{addr: d.addr, id: d.id, rw: d.rw, flush: d.flush,
                              way_ind: rows[r].way, refill: rows[r].refill,
                              evict: rows[r].evict, evict_tag: rows[r].etag};
    exp_miss             <= rows[r].miss;
    row_idx              <= r;
    desc_i               <= d;
    valid_i              <= 1'b1;
    do @(posedge clk_i); while (!ready_o);
    valid_i <= 1'b0;
    // line still held from the row before
    if (rows[r].late) begin
      blocked <= 1'b1;
      repeat (10) @(posedge clk_i);
      send_unlock(r, 1'b1);
    end
    while (pass_cnt + fail_cnt <= r) @(posedge clk_i);
    if (rows[r].unlock) begin
      send_unlock(r, 1'b0);
    end
    for (int k = 0; k < int'(rows[r].downs); k++) begin
      cnt_down_i <= '{id: rows[r].id, rw: d.rw, valid: 1'b1};
      @(posedge clk_i);
      cnt_down_i.valid <= 1'b0;
      @(posedge clk_i);
    end
  endtask

  initial begin
    rst_i          = 1'b1;
    desc_i         = '0;
    valid_i        = 1'b0;
    w_unlock_i     = '0;
    w_unlock_req_i = 1'b0;
    r_unlock_i     = '0;
    r_unlock_req_i = 1'b0;
    cnt_down_i     = '0;
    exp_desc       = '0;
    exp_miss       = 1'b0;
    row_idx        = 0;
    blocked        = 1'b0;
    misc_errs      = 0;
    // cold miss, then hits and a dirtying write on set 3
    add_row(2'd0, 24'h0000a1, 4'd3, 4'd1, 4'b0001, 1, 0, 2'd1, 1, 1, 0, 24'h0);
    add_row(2'd0, 24'h0000a1, 4'd3, 4'd1, 4'b0001, 1, 0, 2'd0, 0, 0, 0, 24'h0);
    add_row(2'd1, 24'h0000a1, 4'd3, 4'd1, 4'b0001, 1, 0, 2'd0, 0, 0, 0, 24'h0);
    // fill the set, fifth tag evicts the dirty way 0
    add_row(2'd0, 24'h0000b2, 4'd3, 4'd1, 4'b0010, 1, 0, 2'd1, 1, 1, 0, 24'h0);
    add_row(2'd0, 24'h0000c3, 4'd3, 4'd1, 4'b0100, 1, 0, 2'd1, 1, 1, 0, 24'h0);
    add_row(2'd0, 24'h0000d4, 4'd3, 4'd1, 4'b1000, 1, 0, 2'd1, 1, 1, 0, 24'h0);
    add_row(2'd0, 24'h0000e5, 4'd3, 4'd1, 4'b0001, 1, 0, 2'd1, 1, 1, 1, 24'h0000a1);
    // left locked, the next access waits for the unlock
    add_row(2'd0, 24'h0000b2, 4'd3, 4'd1, 4'b0010, 0, 0, 2'd0, 0, 0, 0, 24'h0);
    add_row(2'd0, 24'h0000b2, 4'd3, 4'd1, 4'b0010, 1, 1, 2'd0, 0, 0, 0, 24'h0);
    // outstanding miss of id 2 turns a hit to the miss path
    add_row(2'd0, 24'h0000f6, 4'd5, 4'd2, 4'b0001, 1, 0, 2'd0, 1, 1, 0, 24'h0);
    add_row(2'd0, 24'h0000f6, 4'd5, 4'd2, 4'b0001, 1, 0, 2'd2, 1, 0, 0, 24'h0);
    add_row(2'd0, 24'h0000f6, 4'd5, 4'd2, 4'b0001, 1, 0, 2'd0, 0, 0, 0, 24'h0);
    // dirty the line, flush it, then miss on it again
    add_row(2'd1, 24'h0000f6, 4'd5, 4'd3, 4'b0001, 1, 0, 2'd0, 0, 0, 0, 24'h0);
    add_row(2'd2, 24'h0000f6, 4'd5, 4'd3, 4'b0001, 0, 0, 2'd0, 1, 0, 1, 24'h0000f6);
    add_row(2'd0, 24'h0000f6, 4'd5, 4'd3, 4'b0001, 1, 0, 2'd1, 1, 1, 0, 24'h0);
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end
    repeat (4) @(posedge clk_i);
    $display("rows: %0d passed: %0d failed: %0d other errors: %0d",
             num_rows, pass_cnt, fail_cnt, misc_errs);
    if (fail_cnt == 0 && misc_errs == 0 && pass_cnt == num_rows) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: source/hit_miss_ctrl.sv
// descriptor control of the hit/miss stage, one descriptor in flight
// the route is frozen once an output valid is shown
`timescale 1ns/1ps

module hit_miss_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  llc_desc_pkg::desc_t      desc_i,
  input  logic                     valid_i,
  output logic                     ready_o,
  output llc_desc_pkg::desc_t      desc_o,
  output logic                     hit_valid_o,
  input  logic                     hit_ready_i,
  output logic                     miss_valid_o,
  input  logic                     miss_ready_i,
  output llc_desc_pkg::store_req_t store_req_o,
  output logic                     store_req_valid_o,
  input  logic                     store_ready_i,
  input  llc_desc_pkg::store_res_t store_res_i,
  output logic                     update_o,
  output llc_desc_pkg::lock_t      lock_o,
  output logic                     lock_req_o,
  input  logic                     locked_i,
  output llc_desc_pkg::cnt_t       cnt_up_o,
  input  logic                     to_miss_i,
  input  logic                     stall_i
);

  // control state
  logic                init_q;
  logic                busy_q;
  logic                hold_q;
  logic                hold_miss_q;
  // held descriptor
  llc_desc_pkg::desc_t desc_q;
  logic                accept;
  logic                route_miss;
  logic                out_valid;
  logic                xfer;

  //////////////////////////////////////////////////
  // input side and tag store request
  //////////////////////////////////////////////////

  // only take a descriptor when empty and the tags are cleared
  assign ready_o = init_q & ~busy_q & store_ready_i;
  assign accept  = valid_i & ready_o;

  always_comb begin
    // until init is seen, keep asking for the sweep result
    store_req_o       = '0;
    store_req_o.mode  = llc_desc_pkg::mode_init;
    store_req_valid_o = ~init_q;
    if (init_q) begin
      store_req_o.mode    = desc_i.flush ? llc_desc_pkg::mode_flush : llc_desc_pkg::mode_lookup;
      store_req_o.index   = desc_i.addr.fields.index;
      store_req_o.tag     = desc_i.addr.fields.tag;
      store_req_o.dirty   = desc_i.rw;
      store_req_o.way_ind = desc_i.way_ind;
      store_req_valid_o   = valid_i & ~busy_q;
    end
  end

  //////////////////////////////////////////////////
  // output merge and routing
  //////////////////////////////////////////////////

  // tag response is valid from the cycle after acceptance
  always_comb begin
    desc_o           = desc_q;
    desc_o.evict     = store_res_i.evict;
    desc_o.evict_tag = store_res_i.evict_tag;
    desc_o.refill    = 1'b0;
    // flush keeps its target way
    if (!desc_q.flush) begin
      desc_o.way_ind = store_res_i.way_ind;
      desc_o.refill  = ~store_res_i.hit;
    end
  end

  // hits with older misses of the same ID go the miss way too,
  // a hit response already carries no refill and no evict
  assign route_miss = hold_q ? hold_miss_q :
                      (desc_q.flush | ~store_res_i.hit | to_miss_i);
  // flush waits on the lock only, lookups also on the counter
  assign out_valid  = busy_q & (hold_q | ~(locked_i | (stall_i & ~desc_q.flush)));

  assign hit_valid_o  = out_valid & ~route_miss;
  assign miss_valid_o = out_valid & route_miss;
  assign xfer         = (hit_valid_o & hit_ready_i) | (miss_valid_o & miss_ready_i);

  //////////////////////////////////////////////////
  // side effects of an output transfer
  //////////////////////////////////////////////////

  // a hit sent down the miss path leaves the tags alone
  assign update_o       = xfer & (desc_q.flush | ~store_res_i.hit | hit_valid_o);
  assign lock_o.index   = desc_q.addr.fields.index;
  assign lock_o.way_ind = desc_o.way_ind;
  assign lock_req_o     = xfer & ~desc_q.flush;
  assign cnt_up_o.id    = desc_q.id;
  assign cnt_up_o.rw    = desc_q.rw;
  assign cnt_up_o.valid = miss_valid_o & miss_ready_i & ~desc_q.flush;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      init_q <= 1'b0;
      busy_q <= 1'b0;
      hold_q <= 1'b0;
    end else begin
      if (!init_q && store_ready_i) begin
        init_q <= 1'b1;
      end
      if (accept) begin
        busy_q <= 1'b1;
      end else if (xfer) begin
        busy_q <= 1'b0;
      end
      // shown but not taken, keep the route next cycle
      hold_q <= (hit_valid_o | miss_valid_o) & ~xfer;
    end
  end

  always_ff @(posedge clk_i) begin
    hold_miss_q <= miss_valid_o;
    if (accept) begin
      desc_q <= desc_i;
    end
  end

endmodule

// File: source/hit_miss_unit.sv
// hit/miss stage top, holds one descriptor at a time
// no descriptor is taken until the tag sweep after reset is done
`timescale 1ns/1ps

module hit_miss_unit #(
  // width of each per-ID miss counter
  parameter int unsigned cnt_width = 3
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  llc_desc_pkg::desc_t desc_i,
  input  logic                valid_i,
  output logic                ready_o,
  output llc_desc_pkg::desc_t desc_o,
  output logic                hit_valid_o,
  input  logic                hit_ready_i,
  output logic                miss_valid_o,
  input  logic                miss_ready_i,
  input  llc_desc_pkg::lock_t w_unlock_i,
  input  logic                w_unlock_req_i,
  output logic                w_unlock_gnt_o,
  input  llc_desc_pkg::lock_t r_unlock_i,
  input  logic                r_unlock_req_i,
  output logic                r_unlock_gnt_o,
  input  llc_desc_pkg::cnt_t  cnt_down_i
);

  // tag store channel
  llc_desc_pkg::store_req_t store_req;
  logic                     store_req_valid;
  logic                     store_ready;
  llc_desc_pkg::store_res_t store_res;
  logic                     update;
  // lock table channel
  llc_desc_pkg::lock_t      lock;
  logic                     lock_req;
  logic                     locked;
  // miss counter channel
  llc_desc_pkg::cnt_t       cnt_up;
  logic                     to_miss;
  logic                     stall;

  hit_miss_ctrl i_ctrl (
    .clk_i             ( clk_i           ),
    .rst_i             ( rst_i           ),
    .desc_i            ( desc_i          ),
    .valid_i           ( valid_i         ),
    .ready_o           ( ready_o         ),
    .desc_o            ( desc_o          ),
    .hit_valid_o       ( hit_valid_o     ),
    .hit_ready_i       ( hit_ready_i     ),
    .miss_valid_o      ( miss_valid_o    ),
    .miss_ready_i      ( miss_ready_i    ),
    .store_req_o       ( store_req       ),
    .store_req_valid_o ( store_req_valid ),
    .store_ready_i     ( store_ready     ),
    .store_res_i       ( store_res       ),
    .update_o          ( update          ),
    .lock_o            ( lock            ),
    .lock_req_o        ( lock_req        ),
    .locked_i          ( locked          ),
    .cnt_up_o          ( cnt_up          ),
    .to_miss_i         ( to_miss         ),
    .stall_i           ( stall           )
  );

  tag_store i_tag_store (
    .clk_i             ( clk_i           ),
    .rst_i             ( rst_i           ),
    .store_req_i       ( store_req       ),
    .store_req_valid_i ( store_req_valid ),
    .store_ready_o     ( store_ready     ),
    .store_res_o       ( store_res       ),
    .update_i          ( update          )
  );

  lock_table i_lock_table (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .lock_i         ( lock           ),
    .lock_req_i     ( lock_req       ),
    .locked_o       ( locked         ),
    .w_unlock_i     ( w_unlock_i     ),
    .w_unlock_req_i ( w_unlock_req_i ),
    .w_unlock_gnt_o ( w_unlock_gnt_o ),
    .r_unlock_i     ( r_unlock_i     ),
    .r_unlock_req_i ( r_unlock_req_i ),
    .r_unlock_gnt_o ( r_unlock_gnt_o )
  );

  // counters are queried with the ID of the held descriptor
  miss_counters #(
    .cnt_width ( cnt_width )
  ) i_miss_counters (
    .clk_i      ( clk_i      ),
    .rst_i      ( rst_i      ),
    .query_id_i ( desc_o.id  ),
    .cnt_up_i   ( cnt_up     ),
    .cnt_down_i ( cnt_down_i ),
    .to_miss_o  ( to_miss    ),
    .stall_o    ( stall      )
  );

endmodule

// File: source/llc_desc_pkg.sv
// descriptor and internal message types of the hit/miss stage
// way_ind in desc_t is the flush target on input and the chosen way on output
package llc_desc_pkg;

  //////////////////////////////////////////////////
  // descriptor
  //////////////////////////////////////////////////

  typedef struct packed {
    llc_geom_pkg::addr_t    addr;
    llc_geom_pkg::id_t      id;
    // 0 read, 1 write
    logic                   rw;
    logic                   flush;
    llc_geom_pkg::way_ind_t way_ind;
    // line must be fetched from memory
    logic                   refill;
    // victim line is dirty and must be written back
    logic                   evict;
    llc_geom_pkg::tag_t     evict_tag;
  } desc_t;

  // one cache line held by a downstream unit
  typedef struct packed {
    llc_geom_pkg::index_t   index;
    llc_geom_pkg::way_ind_t way_ind;
  } lock_t;

  // miss count strobe for one ID
  typedef struct packed {
    llc_geom_pkg::id_t id;
    logic              rw;
    logic              valid;
  } cnt_t;

  //////////////////////////////////////////////////
  // tag store interface
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    mode_init   = 2'd0,
    mode_lookup = 2'd1,
    mode_flush  = 2'd2
  } tag_mode_e;

  typedef struct packed {
    tag_mode_e              mode;
    llc_geom_pkg::index_t   index;
    llc_geom_pkg::tag_t     tag;
    // lookup comes from a write
    logic                   dirty;
    // flush target, ignored on lookup
    llc_geom_pkg::way_ind_t way_ind;
  } store_req_t;

  typedef struct packed {
    logic                   hit;
    llc_geom_pkg::way_ind_t way_ind;
    logic                   evict;
    llc_geom_pkg::tag_t     evict_tag;
  } store_res_t;

endpackage

// File: source/llc_geom_pkg.sv
// cache geometry shared by all hit/miss stage blocks
// 32-bit addresses only, sizes are fixed here and not parameterized per instance
package llc_geom_pkg;

  //////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////

  // four ways in each of sixteen sets
  localparam int unsigned num_ways     = 4;
  localparam int unsigned num_sets     = 16;
  // 16-byte lines
  localparam int unsigned offset_width = 4;
  localparam int unsigned index_width  = 4;
  // everything above index and offset
  localparam int unsigned tag_width    = 24;
  localparam int unsigned id_width     = 4;

  //////////////////////////////////////////////////
  // basic types
  //////////////////////////////////////////////////

  typedef logic [tag_width-1:0]   tag_t;
  typedef logic [index_width-1:0] index_t;
  // one bit per way, at most one set
  typedef logic [num_ways-1:0]    way_ind_t;
  typedef logic [id_width-1:0]    id_t;

  // address split into its cache fields
  typedef struct packed {
    tag_t                    tag;
    index_t                  index;
    logic [offset_width-1:0] offset;
  } addr_fields_t;

  // one address word, seen as a raw word or as decoded fields
  typedef union packed {
    logic [31:0]  raw;
    addr_fields_t fields;
  } addr_t;

endpackage

// File: source/lock_table.sv
// exact lock bit per set and way for lines held downstream
// write unlocks win, a refused read unlock must keep its request up
`timescale 1ns/1ps

module lock_table (
  input  logic                clk_i,
  input  logic                rst_i,
  input  llc_desc_pkg::lock_t lock_i,
  input  logic                lock_req_i,
  output logic                locked_o,
  input  llc_desc_pkg::lock_t w_unlock_i,
  input  logic                w_unlock_req_i,
  output logic                w_unlock_gnt_o,
  input  llc_desc_pkg::lock_t r_unlock_i,
  input  logic                r_unlock_req_i,
  output logic                r_unlock_gnt_o
);

  // one bit per way of every set
  llc_geom_pkg::way_ind_t lock_q [llc_geom_pkg::num_sets];
  // unlock chosen this cycle
  llc_desc_pkg::lock_t    unlock;

  // line of the held descriptor is in use downstream
  assign locked_o = |(lock_q[lock_i.index] & lock_i.way_ind);

  // fixed priority, grant in the request cycle
  assign w_unlock_gnt_o = w_unlock_req_i;
  assign r_unlock_gnt_o = r_unlock_req_i & ~w_unlock_req_i;
  assign unlock         = w_unlock_req_i ? w_unlock_i : r_unlock_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int s = 0; s < llc_geom_pkg::num_sets; s++) begin
        lock_q[s] <= '0;
      end
    end else begin
      if (w_unlock_gnt_o || r_unlock_gnt_o) begin
        lock_q[unlock.index] <= lock_q[unlock.index] & ~unlock.way_ind;
      end
      // a new lock wins over an unlock of the same line
      // other ways of the same set still see their unlock
      if (lock_req_i) begin
        lock_q[lock_i.index] <= (lock_q[lock_i.index] &
                                 ~(((w_unlock_gnt_o || r_unlock_gnt_o) &&
                                    (unlock.index == lock_i.index)) ?
                                   unlock.way_ind : '0)) | lock_i.way_ind;
      end
    end
  end

endmodule

// File: source/miss_counters.sv
// outstanding-miss counter per ID, saturating at both ends
// up and down strobes for the same ID in one cycle cancel
`timescale 1ns/1ps

module miss_counters #(
  parameter int unsigned cnt_width = 3
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  llc_geom_pkg::id_t  query_id_i,
  input  llc_desc_pkg::cnt_t cnt_up_i,
  input  llc_desc_pkg::cnt_t cnt_down_i,
  output logic               to_miss_o,
  output logic               stall_o
);

  localparam int unsigned num_ids = 1 << llc_geom_pkg::id_width;

  logic [cnt_width-1:0] cnt_q [num_ids];

  // older misses of this ID still in flight
  assign to_miss_o = (cnt_q[query_id_i] != '0);
  // one more miss would overflow
  assign stall_o   = (cnt_q[query_id_i] == '1);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < num_ids; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < num_ids; i++) begin
        if (cnt_up_i.valid && (cnt_up_i.id == llc_geom_pkg::id_t'(i)) &&
            !(cnt_down_i.valid && (cnt_down_i.id == llc_geom_pkg::id_t'(i)))) begin
          if (cnt_q[i] != '1) begin
            cnt_q[i] <= cnt_q[i] + 1'b1;
          end
        end else if (cnt_down_i.valid && (cnt_down_i.id == llc_geom_pkg::id_t'(i)) &&
                     !(cnt_up_i.valid && (cnt_up_i.id == llc_geom_pkg::id_t'(i)))) begin
          if (cnt_q[i] != '0) begin
            cnt_q[i] <= cnt_q[i] - 1'b1;
          end
        end
      end
    end
  end

endmodule

// File: source/tag_store.sv
// tag, valid and dirty state of all sets with a registered lookup response
// sweeps one set per cycle after reset, a pending lookup is applied on update_i
`timescale 1ns/1ps

module tag_store (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  llc_desc_pkg::store_req_t store_req_i,
  input  logic                     store_req_valid_i,
  output logic                     store_ready_o,
  output llc_desc_pkg::store_res_t store_res_o,
  input  logic                     update_i
);

  localparam int unsigned num_ways = llc_geom_pkg::num_ways;
  localparam int unsigned num_sets = llc_geom_pkg::num_sets;
  localparam int unsigned way_bits = $clog2(num_ways);

  // storage arrays
  llc_geom_pkg::tag_t       tag_q   [num_sets][num_ways];
  llc_geom_pkg::way_ind_t   valid_q [num_sets];
  llc_geom_pkg::way_ind_t   dirty_q [num_sets];
  // round-robin victim pointer per set
  logic [way_bits-1:0]      rr_q    [num_sets];
  // init sweep
  llc_geom_pkg::index_t     sweep_idx_q;
  logic                     ready_q;
  // lookup
  llc_desc_pkg::store_req_t pend_q;
  llc_desc_pkg::store_res_t res_d;
  llc_geom_pkg::way_ind_t   hit_vec;
  llc_geom_pkg::way_ind_t   victim;
  llc_geom_pkg::way_ind_t   sel_way;
  llc_geom_pkg::tag_t       sel_tag;
  logic                     inv_found;
  logic                     look_en;

  assign store_ready_o = ready_q;
  // init requests are only a handshake on the sweep
  assign look_en = store_req_valid_i & ready_q &
                   (store_req_i.mode != llc_desc_pkg::mode_init);

  //////////////////////////////////////////////////
  // compare and victim choice
  //////////////////////////////////////////////////

  always_comb begin
    hit_vec   = '0;
    victim    = '0;
    inv_found = 1'b0;
    sel_tag   = '0;
    for (int w = 0; w < num_ways; w++) begin
      hit_vec[w] = valid_q[store_req_i.index][w] &&
                   (tag_q[store_req_i.index][w] == store_req_i.tag);
      // lowest free way first
      if (!valid_q[store_req_i.index][w] && !inv_found) begin
        victim[w] = 1'b1;
        inv_found = 1'b1;
      end
    end
    if (!inv_found) begin
      victim[rr_q[store_req_i.index]] = 1'b1;
    end
    if (store_req_i.mode == llc_desc_pkg::mode_flush) begin
      sel_way = store_req_i.way_ind;
    end else begin
      sel_way = (|hit_vec) ? hit_vec : victim;
    end
    for (int w = 0; w < num_ways; w++) begin
      if (sel_way[w]) begin
        sel_tag = sel_tag | tag_q[store_req_i.index][w];
      end
    end
    res_d.hit       = |hit_vec;
    res_d.way_ind   = sel_way;
    // a lookup hit never evicts
    res_d.evict     = ((store_req_i.mode == llc_desc_pkg::mode_flush) | ~(|hit_vec)) &
                      (|(valid_q[store_req_i.index] & dirty_q[store_req_i.index] & sel_way));
    res_d.evict_tag = sel_tag;
  end

  //////////////////////////////////////////////////
  // arrays, sweep and update
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!ready_q) begin
      valid_q[sweep_idx_q] <= '0;
      dirty_q[sweep_idx_q] <= '0;
      rr_q[sweep_idx_q]    <= '0;
      for (int w = 0; w < num_ways; w++) begin
        tag_q[sweep_idx_q][w] <= '0;
      end
    end else if (update_i) begin
      if (pend_q.mode == llc_desc_pkg::mode_flush) begin
        valid_q[pend_q.index] <= valid_q[pend_q.index] & ~store_res_o.way_ind;
        dirty_q[pend_q.index] <= dirty_q[pend_q.index] & ~store_res_o.way_ind;
      end else if (store_res_o.hit) begin
        // write hit
        if (pend_q.dirty) begin
          dirty_q[pend_q.index] <= dirty_q[pend_q.index] | store_res_o.way_ind;
        end
      end else begin
        // refill the victim
        for (int w = 0; w < num_ways; w++) begin
          if (store_res_o.way_ind[w]) begin
            tag_q[pend_q.index][w]   <= pend_q.tag;
            valid_q[pend_q.index][w] <= 1'b1;
            dirty_q[pend_q.index][w] <= pend_q.dirty;
          end
        end
        rr_q[pend_q.index] <= rr_q[pend_q.index] + 1'b1;
      end
    end
    if (look_en) begin
      pend_q      <= store_req_i;
      store_res_o <= res_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sweep_idx_q <= '0;
      ready_q     <= 1'b0;
    end else if (!ready_q) begin
      sweep_idx_q <= sweep_idx_q + 1'b1;
      if (sweep_idx_q == llc_geom_pkg::index_t'(num_sets - 1)) begin
        ready_q <= 1'b1;
      end
    end
  end

endmodule
